/* hw/core_pkg.sv */
// Core glue shared definitions
`default_nettype none

package core_pkg;

	// Game mode codes written by the loader at the mode index
	typedef logic [7:0] mode_t;

	localparam mode_t MODE_ROBOTRON = 8'd0;
	localparam mode_t MODE_JOUST    = 8'd1;
	localparam mode_t MODE_BUBBLES  = 8'd3;
	localparam mode_t MODE_PLAYBALL = 8'd7;

	// Player inputs, bits 8 and 9 carry fire e and fire f
	typedef logic [9:0] player_t;

	localparam int P_RIGHT  = 0;
	localparam int P_LEFT   = 1;
	localparam int P_DOWN   = 2;
	localparam int P_UP     = 3;
	localparam int P_FIRE_A = 4;
	localparam int P_FIRE_B = 5;
	localparam int P_FIRE_C = 6;
	localparam int P_FIRE_D = 7;

	// System buttons
	typedef logic [3:0] sys_t;

	localparam int SYS_START1  = 0;
	localparam int SYS_START2  = 1;
	localparam int SYS_COIN1   = 2;
	localparam int SYS_ADVANCE = 3;

	// Board joystick bus, active low
	typedef logic [7:0] stick_t;

	//////////////////////////////////////////////////////////////////////
	// Loader and memory
	localparam logic [7:0] IDX_ROM_MODE = 8'd1;
	localparam logic [7:0] IDX_DIP      = 8'd254;
	localparam logic [7:0] IDX_NVRAM    = 8'd4;

	localparam int IOCTL_ADDR_W = 25;
	localparam int NVRAM_ADDR_W = 10;

	//////////////////////////////////////////////////////////////////////
	// Video timing, horizontal values count pixel pairs
	localparam int CNT_W      = 11;
	localparam int HBLANK_ON  = 336;
	localparam int HBLANK_OFF = 40;
	localparam int VBLANK_ON  = 254;
	localparam int VBLANK_OFF = 14;

endpackage

`default_nettype wire

/* hw/mem_port_if.sv */
// Work RAM requester bus
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if #(
	parameter int ADDR_W = core_pkg::NVRAM_ADDR_W
) ();

	logic [ADDR_W-1:0] addr;
	logic [7:0]        wdata;
	logic              we;
	logic              rd;
	// Valid the cycle after a granted rd
	logic [7:0]        rdata;

	modport requester (output addr, wdata, we, rd, input rdata);
	modport arbiter (input addr, wdata, we, rd, output rdata);

endinterface

`default_nettype wire

/* hw/config_regs.sv */
// Loader configuration registers
`timescale 1ns/1ps
`default_nettype none

module config_regs (
	input  wire                                clk_sys,
	input  wire                                rst_n,
	input  wire                                ioctl_wr,
	input  wire [core_pkg::IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  wire [7:0]                          ioctl_index,
	input  wire [7:0]                          ioctl_dout,
	output core_pkg::mode_t                    mode,
	output logic [7:0]                         dip0
);

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mode <= '0;
			dip0 <= '0;
		end
		else if (ioctl_wr)
		begin
			if (ioctl_index == core_pkg::IDX_ROM_MODE)
				mode <= ioctl_dout;
			// Only the first switch byte is kept
			if (ioctl_index == core_pkg::IDX_DIP && ioctl_addr == '0)
				dip0 <= ioctl_dout;
		end
	end

endmodule

`default_nettype wire

/* hw/control_mapper.sv */
// Per-game control mapping
`timescale 1ns/1ps
`default_nettype none

module control_mapper (
	input  wire                     clk_sys,
	input  wire                     rst_n,
	input  wire core_pkg::mode_t    mode,
	input  wire [7:0]               dip0,
	input  wire core_pkg::player_t  p1,
	input  wire core_pkg::player_t  p2,
	input  wire core_pkg::sys_t     sys,
	input  wire                     twin_stick,
	input  wire                     move_fire,
	output core_pkg::stick_t        ja,
	output core_pkg::stick_t        jb,
	output logic [2:0]              btn,
	output logic [7:0]              sw
);

	core_pkg::player_t pc;
	core_pkg::stick_t  ja_d;
	core_pkg::stick_t  jb_d;
	logic [2:0]        btn_d;
	logic [3:0]        hi;
	logic [3:0]        lo;

	// Stick nibble as right, left, down, up from the top
	function automatic logic [3:0] stick4(input core_pkg::player_t p);
		return {p[core_pkg::P_RIGHT], p[core_pkg::P_LEFT], p[core_pkg::P_DOWN], p[core_pkg::P_UP]};
	endfunction

	assign pc = p1 | p2;

	always_comb
	begin
		ja_d  = '1;
		jb_d  = '1;
		btn_d = '0;
		// Robotron nibbles, also used as defaults
		hi = twin_stick ? stick4(p2) :
			move_fire ? stick4(pc) :
			{pc[core_pkg::P_FIRE_A], pc[core_pkg::P_FIRE_D],
			pc[core_pkg::P_FIRE_B], pc[core_pkg::P_FIRE_C]};
		lo = twin_stick ? stick4(p1) : stick4(pc);

		case (mode)
			core_pkg::MODE_ROBOTRON:
			begin
				btn_d = {sys[core_pkg::SYS_START1], sys[core_pkg::SYS_START2],
					sys[core_pkg::SYS_COIN1]};
				ja_d  = ~{hi, lo};
				jb_d  = ~{hi, lo};
			end
			core_pkg::MODE_JOUST:
			begin
				btn_d = {sys[core_pkg::SYS_START2], sys[core_pkg::SYS_START1],
					sys[core_pkg::SYS_COIN1]};
				ja_d  = ~{5'b0, p1[core_pkg::P_FIRE_A], p1[core_pkg::P_RIGHT], p1[core_pkg::P_LEFT]};
				jb_d  = ~{5'b0, p2[core_pkg::P_FIRE_A], p2[core_pkg::P_RIGHT], p2[core_pkg::P_LEFT]};
			end
			core_pkg::MODE_BUBBLES:
			begin
				btn_d = {sys[core_pkg::SYS_START2], sys[core_pkg::SYS_START1],
					sys[core_pkg::SYS_COIN1]};
				ja_d  = ~{4'b0, stick4(pc)};
				jb_d  = ~{4'b0, stick4(pc)};
			end
			core_pkg::MODE_PLAYBALL:
			begin
				// Start buttons sit on the stick bus here
				btn_d = {2'b0, sys[core_pkg::SYS_COIN1]};
				ja_d  = ~{4'b0, sys[core_pkg::SYS_START2], pc[core_pkg::P_RIGHT],
					pc[core_pkg::P_LEFT], sys[core_pkg::SYS_START1]};
				jb_d  = ja_d;
			end
			default:
			begin
				ja_d = '1;
				jb_d = '1;
			end
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ja  <= '1;
			jb  <= '1;
			btn <= '0;
			sw  <= '0;
		end
		else
		begin
			ja  <= ja_d;
			jb  <= jb_d;
			btn <= btn_d;
			sw  <= dip0 | {6'b0, sys[core_pkg::SYS_ADVANCE], 1'b0};
		end
	end

endmodule

`default_nettype wire

/* hw/nvram_port.sv */
// High-score nvram loader port
`timescale 1ns/1ps
`default_nettype none

module nvram_port #(
	parameter int ADDR_W = core_pkg::NVRAM_ADDR_W
) (
	input  wire                                clk_sys,
	input  wire                                rst_n,
	input  wire                                ioctl_wr,
	input  wire [core_pkg::IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  wire [7:0]                          ioctl_dout,
	input  wire [7:0]                          ioctl_index,
	input  wire                                ioctl_download,
	input  wire                                ioctl_upload,
	output logic [7:0]                         ioctl_din,
	mem_port_if.requester                      bus
);

	logic              nv_dl;
	logic              nv_ul;
	logic              rd_q;
	logic [ADDR_W-1:0] addr_q;

	assign nv_dl = ioctl_download && (ioctl_index == core_pkg::IDX_NVRAM);
	assign nv_ul = ioctl_upload && (ioctl_index == core_pkg::IDX_NVRAM);

	// Upload request register, one read per cycle
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			rd_q <= 1'b0;
		else
			rd_q <= nv_ul;
	end

	always_ff @(posedge clk_sys)
	begin
		addr_q <= ioctl_addr[ADDR_W-1:0];
	end

	assign bus.addr  = nv_dl ? ioctl_addr[ADDR_W-1:0] : addr_q;
	assign bus.wdata = ioctl_dout;
	assign bus.we    = nv_dl & ioctl_wr;
	// Idle reads between download strobes keep the RAM claimed
	assign bus.rd    = (nv_dl & ~ioctl_wr) | rd_q;

	assign ioctl_din = bus.rdata;

endmodule

`default_nettype wire

/* hw/mem_arbiter.sv */
// Work RAM arbiter, nvram first
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
	parameter int ADDR_W = core_pkg::NVRAM_ADDR_W
) (
	input  wire                 clk_sys,
	input  wire                 rst_n,
	mem_port_if.arbiter         nv,
	mem_port_if.arbiter         cpu,
	output logic                mem_busy,
	output logic [ADDR_W-1:0]   ram_addr,
	output logic [7:0]          ram_wdata,
	output logic                ram_we,
	input  wire [7:0]           ram_rdata
);

	logic nv_act;
	logic nv_rd_q;
	logic cpu_rd_q;

	assign nv_act   = nv.we | nv.rd;
	assign mem_busy = nv_act;

	assign ram_addr  = nv_act ? nv.addr : cpu.addr;
	assign ram_wdata = nv_act ? nv.wdata : cpu.wdata;
	assign ram_we    = nv_act ? nv.we : cpu.we;

	// Owner of the read now in flight through the RAM
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			nv_rd_q  <= 1'b0;
			cpu_rd_q <= 1'b0;
		end
		else
		begin
			nv_rd_q  <= nv_act & nv.rd;
			cpu_rd_q <= ~nv_act & cpu.rd;
		end
	end

	assign nv.rdata  = nv_rd_q ? ram_rdata : 8'h00;
	assign cpu.rdata = cpu_rd_q ? ram_rdata : 8'h00;

endmodule

`default_nettype wire

/* hw/work_ram.sv */
// Byte-wide work RAM
`timescale 1ns/1ps
`default_nettype none

module work_ram #(
	parameter int ADDR_W = core_pkg::NVRAM_ADDR_W
) (
	input  wire                 clk_sys,
	input  wire [ADDR_W-1:0]    addr,
	input  wire [7:0]           wdata,
	input  wire                 we,
	output logic [7:0]          rdata
);

	logic [7:0] mem [2**ADDR_W];

	// Read returns the old byte on a write cycle
	always_ff @(posedge clk_sys)
	begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

/* hw/blank_gen.sv */
// Blanking from sync pulses
`timescale 1ns/1ps
`default_nettype none

module blank_gen (
	input  wire    clk_sys,
	input  wire    rst_n,
	input  wire    hs,
	input  wire    vs,
	output logic   ce_pix,
	output logic   hblank,
	output logic   vblank
);

	logic [core_pkg::CNT_W-1:0] pcnt;
	logic [core_pkg::CNT_W-1:0] lcnt;
	logic                       hs_q;
	logic                       vs_q;
	logic                       hs_rise;

	assign hs_rise = hs & ~hs_q;
	assign ce_pix  = pcnt[0];

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pcnt   <= '0;
			lcnt   <= '0;
			hs_q   <= 1'b0;
			vs_q   <= 1'b0;
			hblank <= 1'b0;
			vblank <= 1'b0;
		end
		else
		begin
			hs_q <= hs;
			if (pcnt != '1)
				pcnt <= pcnt + 1'b1;

			// vs is only looked at on line starts
			if (hs_rise)
			begin
				pcnt <= '0;
				vs_q <= vs;
				if (vs & ~vs_q)
					lcnt <= '0;
				else if (lcnt != '1)
					lcnt <= lcnt + 1'b1;
			end

			if (pcnt[core_pkg::CNT_W-1:1] == core_pkg::HBLANK_ON)
				hblank <= 1'b1;
			if (pcnt[core_pkg::CNT_W-1:1] == core_pkg::HBLANK_OFF)
				hblank <= 1'b0;

			if (lcnt == core_pkg::VBLANK_ON)
				vblank <= 1'b1;
			if (lcnt == core_pkg::VBLANK_OFF)
				vblank <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/core_top.sv */
// Williams board glue top level
`timescale 1ns/1ps
`default_nettype none

module core_top #(
	parameter int ADDR_W = core_pkg::NVRAM_ADDR_W
) (
	input  wire                                clk_sys,
	input  wire                                rst_n,
	// Loader
	input  wire                                ioctl_wr,
	input  wire [core_pkg::IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  wire [7:0]                          ioctl_dout,
	input  wire [7:0]                          ioctl_index,
	input  wire                                ioctl_download,
	input  wire                                ioctl_upload,
	output logic [7:0]                         ioctl_din,
	// Controls
	input  wire core_pkg::player_t             p1,
	input  wire core_pkg::player_t             p2,
	input  wire core_pkg::sys_t                sys,
	input  wire                                twin_stick,
	input  wire                                move_fire,
	output core_pkg::stick_t                   ja,
	output core_pkg::stick_t                   jb,
	output logic [2:0]                         btn,
	output logic [7:0]                         sw,
	// CPU side of the work RAM
	input  wire [ADDR_W-1:0]                   cpu_addr,
	input  wire [7:0]                          cpu_wdata,
	input  wire                                cpu_we,
	input  wire                                cpu_rd,
	output logic [7:0]                         cpu_rdata,
	output logic                               mem_busy,
	// Video
	input  wire                                hs,
	input  wire                                vs,
	output logic                               ce_pix,
	output logic                               hblank,
	output logic                               vblank
);

	core_pkg::mode_t   mode;
	logic [7:0]        dip0;
	logic [ADDR_W-1:0] ram_addr;
	logic [7:0]        ram_wdata;
	logic              ram_we;
	logic [7:0]        ram_rdata;

	mem_port_if #(.ADDR_W(ADDR_W)) cpu_bus ();
	mem_port_if #(.ADDR_W(ADDR_W)) nv_bus ();

	assign cpu_bus.addr  = cpu_addr;
	assign cpu_bus.wdata = cpu_wdata;
	assign cpu_bus.we    = cpu_we;
	assign cpu_bus.rd    = cpu_rd;
	assign cpu_rdata     = cpu_bus.rdata;

	config_regs i_config_regs (
		.clk_sys(clk_sys), .rst_n(rst_n), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_index(ioctl_index), .ioctl_dout(ioctl_dout), .mode(mode), .dip0(dip0)
	);

	control_mapper i_control_mapper (
		.clk_sys(clk_sys), .rst_n(rst_n), .mode(mode), .dip0(dip0), .p1(p1), .p2(p2),
		.sys(sys), .twin_stick(twin_stick), .move_fire(move_fire),
		.ja(ja), .jb(jb), .btn(btn), .sw(sw)
	);

	////////////////////////////////////////////////////////////////////
	// Work RAM and its two requesters
	nvram_port #(.ADDR_W(ADDR_W)) i_nvram_port (
		.clk_sys(clk_sys), .rst_n(rst_n), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .ioctl_index(ioctl_index),
		.ioctl_download(ioctl_download), .ioctl_upload(ioctl_upload),
		.ioctl_din(ioctl_din), .bus(nv_bus.requester)
	);

	mem_arbiter #(.ADDR_W(ADDR_W)) i_mem_arbiter (
		.clk_sys(clk_sys), .rst_n(rst_n), .nv(nv_bus.arbiter), .cpu(cpu_bus.arbiter),
		.mem_busy(mem_busy), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
		.ram_we(ram_we), .ram_rdata(ram_rdata)
	);

	work_ram #(.ADDR_W(ADDR_W)) i_work_ram (
		.clk_sys(clk_sys), .addr(ram_addr), .wdata(ram_wdata), .we(ram_we),
		.rdata(ram_rdata)
	);

	blank_gen i_blank_gen (
		.clk_sys(clk_sys), .rst_n(rst_n), .hs(hs), .vs(vs),
		.ce_pix(ce_pix), .hblank(hblank), .vblank(vblank)
	);

endmodule

`default_nettype wire

/* tests/core_tb_checks.svh */
// Testbench drive and compare tasks
`ifndef CORE_TB_CHECKS_SVH
`define CORE_TB_CHECKS_SVH

// Inputs change a short time after the rising edge
task automatic tick(input int n = 1);
	repeat (n)
	begin
		@(posedge clk_sys);
		#2;
	end
endtask

task automatic check_stick(input string name, input core_pkg::stick_t got,
	input core_pkg::stick_t exp);
	if (got !== exp)
	begin
		$display("error: %0t ns %s = %h, expected %h", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp)
	begin
		$display("error: %0t ns %s = %h, expected %h", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("error: %0t ns %s = %b, expected %b", $time, name, got, exp);
		abort_run();
	end
endtask

//////////////////////////////////////////////////////////////////////
// Bus drivers

task automatic loader_write(input logic [7:0] index, input logic [24:0] addr,
	input logic [7:0] data);
	ioctl_index = index;
	ioctl_addr  = addr;
	ioctl_dout  = data;
	ioctl_wr    = 1'b1;
	tick();
	ioctl_wr = 1'b0;
endtask

task automatic cpu_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
	cpu_addr  = addr;
	cpu_wdata = data;
	cpu_we    = 1'b1;
	tick();
	cpu_we = 1'b0;
endtask

// Read data shows up one cycle after the strobe
task automatic cpu_read_expect(input logic [ADDR_W-1:0] addr, input logic [7:0] exp);
	cpu_addr = addr;
	cpu_rd   = 1'b1;
	tick();
	check_byte("cpu_rdata", cpu_rdata, exp);
	cpu_rd = 1'b0;
endtask

// Mapper outputs are registered, so look one cycle later
task automatic apply_controls(input core_pkg::player_t p1_v, input core_pkg::player_t p2_v,
	input core_pkg::sys_t sys_v, input logic twin, input logic mfire,
	input core_pkg::stick_t ja_e, input core_pkg::stick_t jb_e,
	input logic [2:0] btn_e, input logic [7:0] sw_e);
	p1         = p1_v;
	p2         = p2_v;
	sys        = sys_v;
	twin_stick = twin;
	move_fire  = mfire;
	tick();
	check_stick("ja", ja, ja_e);
	check_stick("jb", jb, jb_e);
	check_byte("btn", {5'b0, btn}, {5'b0, btn_e});
	check_byte("sw", sw, sw_e);
endtask

`endif

/* tests/core_tb.sv */
// Core glue testbench
`timescale 1ns/1ps
`default_nettype none

module core_tb;

	localparam int ADDR_W      = core_pkg::NVRAM_ADDR_W;
	localparam int LINE_LEN    = 800;
	localparam int FRAME_LINES = 262;
	localparam int HS_WIDTH    = 32;
	localparam int RAM_BYTES   = 32;
	localparam int NV_BYTES    = 8;
	localparam logic [ADDR_W-1:0] RAM_BASE = 10'h100;
	// 284 video lines plus a few hundred cycles of RAM and mapping traffic
	localparam int TIMEOUT_CYCLES = (FRAME_LINES + 40) * LINE_LEN + 4000;

	logic                              clk_sys;
	logic                              rst_n;
	logic                              ioctl_wr;
	logic [core_pkg::IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [7:0]                        ioctl_dout;
	logic [7:0]                        ioctl_index;
	logic                              ioctl_download;
	logic                              ioctl_upload;
	logic [7:0]                        ioctl_din;
	core_pkg::player_t                 p1;
	core_pkg::player_t                 p2;
	core_pkg::sys_t                    sys;
	logic                              twin_stick;
	logic                              move_fire;
	core_pkg::stick_t                  ja;
	core_pkg::stick_t                  jb;
	logic [2:0]                        btn;
	logic [7:0]                        sw;
	logic [ADDR_W-1:0]                 cpu_addr;
	logic [7:0]                        cpu_wdata;
	logic                              cpu_we;
	logic                              cpu_rd;
	logic [7:0]                        cpu_rdata;
	logic                              mem_busy;
	logic                              hs;
	logic                              vs;
	logic                              ce_pix;
	logic                              hblank;
	logic                              vblank;

	int         cycle_cnt = 0;
	int         pix;
	integer     seed;
	logic [7:0] ram_data [RAM_BYTES];
	logic [7:0] nv_data [NV_BYTES];

	core_top #(.ADDR_W(ADDR_W)) i_core_top (.*);

	`include "core_tb_checks.svh"

	initial
	begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout: no result after %0d clock cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1, "simulation stopped on an error");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic verify_reset_state();
		check_stick("ja", ja, 8'hFF);
		check_stick("jb", jb, 8'hFF);
		check_byte("btn", {5'b0, btn}, 8'h00);
		check_byte("sw", sw, 8'h00);
		check_bit("hblank", hblank, 1'b0);
		check_bit("vblank", vblank, 1'b0);
		check_bit("mem_busy", mem_busy, 1'b0);
	endtask

	task automatic run_mapping();
		loader_write(core_pkg::IDX_ROM_MODE, '0, core_pkg::MODE_JOUST);
		loader_write(core_pkg::IDX_DIP, '0, 8'hA4);
		// Second switch byte must not reach sw
		loader_write(core_pkg::IDX_DIP, 25'd1, 8'h5B);
		apply_controls(10'h011, 10'h002, 4'b0101, 1'b0, 1'b0, 8'hF9, 8'hFE, 3'b011, 8'hA4);
		loader_write(core_pkg::IDX_ROM_MODE, '0, core_pkg::MODE_ROBOTRON);
		// Twin stick, advance held
		apply_controls(10'h009, 10'h004, 4'b1010, 1'b1, 1'b0, 8'hD6, 8'hD6, 3'b010, 8'hA6);
		// Fire buttons on the high nibble as a, d, b, c
		apply_controls(10'h022, 10'h080, 4'b0100, 1'b0, 1'b0, 8'h9B, 8'h9B, 3'b001, 8'hA4);
		apply_controls(10'h022, 10'h080, 4'b0100, 1'b0, 1'b1, 8'hBB, 8'hBB, 3'b001, 8'hA4);
		loader_write(core_pkg::IDX_ROM_MODE, '0, core_pkg::MODE_BUBBLES);
		apply_controls(10'h008, 10'h001, 4'b0011, 1'b0, 1'b0, 8'hF6, 8'hF6, 3'b110, 8'hA4);
		loader_write(core_pkg::IDX_ROM_MODE, '0, core_pkg::MODE_PLAYBALL);
		apply_controls(10'h002, 10'h000, 4'b0101, 1'b0, 1'b0, 8'hFC, 8'hFC, 3'b001, 8'hA4);
		// Unmapped mode leaves the sticks idle
		loader_write(core_pkg::IDX_ROM_MODE, '0, 8'h05);
		apply_controls(10'h3FF, 10'h3FF, 4'b0000, 1'b0, 1'b0, 8'hFF, 8'hFF, 3'b000, 8'hA4);
	endtask

	task automatic cpu_ram_roundtrip();
		for (int i = 0; i < RAM_BYTES; i++)
		begin
			ram_data[i] = 8'($random(seed));
			cpu_write(ADDR_W'(RAM_BASE + i), ram_data[i]);
		end
		for (int i = 0; i < RAM_BYTES; i++)
			cpu_read_expect(ADDR_W'(RAM_BASE + i), ram_data[i]);
	endtask

	task automatic download_priority();
		ioctl_index    = core_pkg::IDX_NVRAM;
		ioctl_download = 1'b1;
		for (int i = 0; i < NV_BYTES; i++)
		begin
			nv_data[i] = 8'($random(seed));
			ioctl_addr = 25'(i);
			ioctl_dout = nv_data[i];
			ioctl_wr   = 1'b1;
			// Competing CPU write to the same byte
			cpu_addr   = ADDR_W'(i);
			cpu_wdata  = ~nv_data[i];
			cpu_we     = 1'b1;
			tick();
			check_bit("mem_busy", mem_busy, 1'b1);
			ioctl_wr  = 1'b0;
			cpu_addr  = RAM_BASE;
			cpu_wdata = ~ram_data[0];
			tick();
			check_bit("mem_busy", mem_busy, 1'b1);
			cpu_we = 1'b0;
		end
		ioctl_download = 1'b0;
		tick();
		check_bit("mem_busy", mem_busy, 1'b0);
		for (int i = 0; i < NV_BYTES; i++)
			cpu_read_expect(ADDR_W'(i), nv_data[i]);
		cpu_read_expect(RAM_BASE, ram_data[0]);
	endtask

	task automatic upload_readback();
		ioctl_index  = core_pkg::IDX_NVRAM;
		ioctl_upload = 1'b1;
		for (int i = 0; i <= NV_BYTES; i++)
		begin
			if (i < NV_BYTES)
				ioctl_addr = 25'(NV_BYTES - 1 - i);
			tick();
			// Byte for the address applied two cycles back
			if (i > 0)
				check_byte("ioctl_din", ioctl_din, nv_data[NV_BYTES - i]);
		end
		ioctl_upload = 1'b0;
		tick();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Video sync

	// Pixel count restarts the cycle after hs rises
	task automatic start_line(input logic vs_level);
		hs = 1'b1;
		vs = vs_level;
		tick();
		pix = 0;
		repeat (HS_WIDTH - 1)
		begin
			tick();
			pix++;
		end
		hs = 1'b0;
		vs = 1'b0;
	endtask

	task automatic wait_pixel(input int target);
		while (pix < target)
		begin
			tick();
			pix++;
		end
	endtask

	task automatic run_lines(input int count);
		repeat (count)
		begin
			start_line(1'b0);
			wait_pixel(LINE_LEN - 1);
		end
	endtask

	task automatic sync_blanking();
		logic prev;
		// One full line first so that hblank is already high
		run_lines(1);
		start_line(1'b1);
		wait_pixel(400);
		check_bit("hblank", hblank, 1'b0);
		prev = ce_pix;
		repeat (16)
		begin
			tick();
			pix++;
			check_bit("ce_pix", ce_pix, ~prev);
			prev = ce_pix;
		end
		wait_pixel(700);
		check_bit("hblank", hblank, 1'b1);
		wait_pixel(LINE_LEN - 1);
		run_lines(255);
		// Line 256
		start_line(1'b0);
		check_bit("vblank", vblank, 1'b1);
		wait_pixel(LINE_LEN - 1);
		run_lines(FRAME_LINES - 257);
		start_line(1'b1);
		wait_pixel(LINE_LEN - 1);
		run_lines(19);
		// Line 20 of the next frame
		start_line(1'b0);
		check_bit("vblank", vblank, 1'b0);
		wait_pixel(LINE_LEN - 1);
	endtask

	initial
	begin
		seed           = 43885;
		rst_n          = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_index    = '0;
		ioctl_download = 1'b0;
		ioctl_upload   = 1'b0;
		p1             = '0;
		p2             = '0;
		sys            = '0;
		twin_stick     = 1'b0;
		move_fire      = 1'b0;
		cpu_addr       = '0;
		cpu_wdata      = '0;
		cpu_we         = 1'b0;
		cpu_rd         = 1'b0;
		hs             = 1'b0;
		vs             = 1'b0;
		pix            = 0;
		tick(16);
		rst_n = 1'b1;
		verify_reset_state();
		run_mapping();
		cpu_ram_roundtrip();
		download_priority();
		upload_readback();
		sync_blanking();
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+tests
hw/core_pkg.sv
hw/mem_port_if.sv
hw/config_regs.sv
hw/control_mapper.sv
hw/nvram_port.sv
hw/mem_arbiter.sv
hw/work_ram.sv
hw/blank_gen.sv
hw/core_top.sv
tests/core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	--top-module core_tb --Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vcore_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0
